//--- bp_index_hash.sv
`timescale 1ns/100ps

module bp_index_hash #(
    parameter int h_width = 8
) (
    input  bp_pkg::addr_t      pc,
    input  bp_pkg::bh_t        bh,
    output logic [h_width-1:0] index
);

    import bp_pkg::*;

    localparam int pc_chunks = (addr_w + h_width - 1) / h_width;
    localparam int bh_chunks = (bh_w + h_width - 1) / h_width;
    localparam int pc_pad_w  = pc_chunks * h_width;
    localparam int bh_pad_w  = bh_chunks * h_width;

    logic [pc_pad_w-1:0] pc_pad;
    logic [bh_pad_w-1:0] bh_pad;

    // Short top chunks are zero-padded.
    assign pc_pad = pc_pad_w'(pc);
    assign bh_pad = bh_pad_w'(bh);

    always_comb begin
        index = '0;
        for (int i = 0; i < pc_chunks; i++) begin
            index = index ^ pc_pad[i*h_width +: h_width];
        end
        for (int j = 0; j < bh_chunks; j++) begin
            index = index ^ bh_pad[j*h_width +: h_width];
        end
    end

endmodule

//--- bp_pkg.sv
package bp_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int addr_w = 30;   // Fetch address in words.
    localparam int bh_w   = 16;   // Global branch history.
    localparam int k_w    = 12;   // Folded pc tag.

    localparam int k_chunks = (addr_w + k_w - 1) / k_w;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [bh_w-1:0]   bh_t;
    typedef logic [k_w-1:0]    tag_t;

    // ==============================
    // Structs
    // ==============================
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        addr_t target;
    } btb_entry_t;

    typedef struct packed {
        addr_t npc;
        logic  taken;
        logic  hit;
        bh_t   bh;      // History used for the lookup, returned on update.
    } bp_pred_t;

    typedef struct packed {
        addr_t pc;
        bh_t   bh;
        addr_t target;  // Resolved next pc.
        logic  taken;   // Actual outcome.
    } bp_update_t;

    // XOR of the pc in k_w-bit chunks; the top chunk is zero-padded.
    function automatic tag_t bp_fold_tag(input addr_t pc);
        logic [k_chunks*k_w-1:0] padded;
        tag_t acc;
        padded = (k_chunks*k_w)'(pc);
        acc = '0;
        for (int i = 0; i < k_chunks; i++) begin
            acc = acc ^ padded[i*k_w +: k_w];
        end
        return acc;
    endfunction

endpackage

//--- branch_predictor.f
bp_pkg.sv
sp_bram.sv
bp_index_hash.sv
btb.sv
pht.sv
ghr.sv
branch_predictor.sv
tb_branch_predictor.sv

//--- branch_predictor.sv
`timescale 1ns/100ps

module branch_predictor #(
    parameter int h_width = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    // Query from fetch.
    input  logic               query_valid,
    input  bp_pkg::addr_t      query_pc,
    // Resolved branch.
    input  logic               update_en,
    input  bp_pkg::bp_update_t update,
    // Prediction, one cycle after the query.
    output logic               pred_valid,
    output bp_pkg::bp_pred_t   pred
);

    import bp_pkg::*;

    bh_t   history;
    bh_t   history_q;
    logic  dir_taken;
    addr_t btb_npc;
    logic  btb_hit;
    logic  btb_taken;

    // ==============================
    // Global history
    // ==============================
    ghr u_ghr (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .query_valid  (query_valid),
        .update_en    (update_en),
        .update_taken (update.taken),
        .history      (history),
        .history_q    (history_q)
    );

    // ==============================
    // Direction counters
    // ==============================
    pht #(
        .h_width (h_width)
    ) u_pht (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .query_pc  (query_pc),
        .bh        (history),
        .update_en (update_en),
        .update    (update),
        .dir_taken (dir_taken)
    );

    // ==============================
    // Target buffer
    // ==============================
    btb #(
        .h_width (h_width)
    ) u_btb (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .query_valid (query_valid),
        .query_pc    (query_pc),
        .bh          (history),
        .update_en   (update_en),
        .update      (update),
        .dir_taken   (dir_taken),
        .pred_valid  (pred_valid),
        .npc         (btb_npc),
        .hit         (btb_hit),
        .taken       (btb_taken)
    );

    // Selection lives in the btb; these are plain field connections.
    assign pred.npc   = btb_npc;
    assign pred.taken = btb_taken;
    assign pred.hit   = btb_hit;
    assign pred.bh    = history_q;

endmodule

//--- btb.sv
`timescale 1ns/100ps

module btb #(
    parameter int h_width = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    // Query.
    input  logic               query_valid,
    input  bp_pkg::addr_t      query_pc,
    input  bp_pkg::bh_t        bh,
    // Update.
    input  logic               update_en,
    input  bp_pkg::bp_update_t update,
    // Registered direction from the pht.
    input  logic               dir_taken,
    // Prediction.
    output logic               pred_valid,
    output bp_pkg::addr_t      npc,
    output logic               hit,
    output logic               taken
);

    import bp_pkg::*;

    localparam btb_entry_t entry_init = '{valid: 1'b0, tag: '0, target: '0};

    logic [h_width-1:0] q_index;
    logic [h_width-1:0] u_index;
    btb_entry_t         rd_entry;
    btb_entry_t         wr_entry;
    addr_t              pc_q;
    addr_t              fallthrough;

    // ==============================
    // Index hashing
    // ==============================
    bp_index_hash #(
        .h_width (h_width)
    ) u_query_hash (
        .pc    (query_pc),
        .bh    (bh),
        .index (q_index)
    );

    bp_index_hash #(
        .h_width (h_width)
    ) u_update_hash (
        .pc    (update.pc),
        .bh    (update.bh),
        .index (u_index)
    );

    // ==============================
    // Entry storage
    // ==============================
    assign wr_entry.valid  = 1'b1;
    assign wr_entry.tag    = bp_fold_tag(update.pc);
    assign wr_entry.target = update.target;

    sp_bram #(
        .addr_width (h_width),
        .data_width ($bits(btb_entry_t)),
        .init_value (entry_init)
    ) u_btb_ram (
        .clk   (clk),
        .raddr (q_index),
        .enb   (!stall),
        .dout  (rd_entry),
        .waddr (u_index),
        .din   (wr_entry),
        .we    (update_en && update.taken)   // Only taken branches are installed.
    );

    // Query pc and valid travel beside the RAM read.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
        end else if (!stall) begin
            pred_valid <= query_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_q <= query_pc;
        end
    end

    // ==============================
    // Next pc selection
    // ==============================
    assign fallthrough = pc_q + (pc_q[0] ? addr_t'(1) : addr_t'(2));   // Aligned pairs.
    assign hit         = rd_entry.valid && (rd_entry.tag == bp_fold_tag(pc_q));
    assign taken       = hit && dir_taken;
    assign npc         = taken ? rd_entry.target : fallthrough;

endmodule

//--- ghr.sv
`timescale 1ns/100ps

module ghr (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        query_valid,
    input  logic        update_en,
    input  logic        update_taken,
    output bp_pkg::bh_t history,
    output bp_pkg::bh_t history_q
);

    import bp_pkg::*;

    logic accept;

    assign accept = query_valid && !stall;

    // ==============================
    // Resolved outcome history
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            history <= '0;
        end else if (update_en) begin
            history <= {history[bh_w-2:0], update_taken};   // Newest at the LSB.
        end
    end

    // ==============================
    // Snapshot per accepted query
    // ==============================
    // Taken before any same-cycle shift, so it matches the index used.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            history_q <= '0;
        end else if (accept) begin
            history_q <= history;
        end
    end

endmodule

//--- pht.sv
`timescale 1ns/100ps

module pht #(
    parameter int h_width = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  bp_pkg::addr_t      query_pc,
    input  bp_pkg::bh_t        bh,
    input  logic               update_en,
    input  bp_pkg::bp_update_t update,
    output logic               dir_taken
);

    import bp_pkg::*;

    typedef logic [1:0] ctr_t;

    localparam int   depth    = 1 << h_width;
    localparam ctr_t ctr_init = 2'b01;   // Weakly not taken.

    ctr_t               counters [depth];
    ctr_t               ctr_q;
    ctr_t               u_ctr;
    ctr_t               u_ctr_next;
    logic [h_width-1:0] q_index;
    logic [h_width-1:0] u_index;

    bp_index_hash #(
        .h_width (h_width)
    ) u_query_hash (
        .pc    (query_pc),
        .bh    (bh),
        .index (q_index)
    );

    bp_index_hash #(
        .h_width (h_width)
    ) u_update_hash (
        .pc    (update.pc),
        .bh    (update.bh),
        .index (u_index)
    );

    // ==============================
    // Saturating update
    // ==============================
    assign u_ctr = counters[u_index];

    always_comb begin
        u_ctr_next = u_ctr;
        if (update.taken && (u_ctr != 2'b11)) begin
            u_ctr_next = u_ctr + 2'd1;
        end else if (!update.taken && (u_ctr != 2'b00)) begin
            u_ctr_next = u_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                counters[i] <= ctr_init;
            end
        end else if (update_en) begin
            counters[u_index] <= u_ctr_next;
        end
    end

    // Lookup reads the old counter on a same-cycle update.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctr_q <= ctr_init;
        end else if (!stall) begin
            ctr_q <= counters[q_index];
        end
    end

    assign dir_taken = ctr_q[1];

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal --top-module tb_branch_predictor -f branch_predictor.f

out=$(./obj_dir/Vtb_branch_predictor)
echo "$out"

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
else
    exit 1
fi

//--- sp_bram.sv
`timescale 1ns/100ps

module sp_bram #(
    parameter int addr_width = 8,
    parameter int data_width = 32,
    parameter logic [data_width-1:0] init_value = '0
) (
    input  logic                  clk,
    input  logic [addr_width-1:0] raddr,
    input  logic                  enb,
    output logic [data_width-1:0] dout,
    input  logic [addr_width-1:0] waddr,
    input  logic [data_width-1:0] din,
    input  logic                  we
);

    localparam int depth = 1 << addr_width;

    logic [data_width-1:0] mem [depth];

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = init_value;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
        if (enb) begin
            dout <= mem[raddr];   // Old data on a same-address write.
        end
    end

endmodule

//--- tb_branch_predictor.sv
`timescale 1ns/100ps

module tb_branch_predictor;

    import bp_pkg::*;

    localparam int h_w          = 8;
    localparam int depth        = 1 << h_w;
    localparam int reset_len    = 16;
    localparam int directed_len = 120;   // Upper bound of the directed part.
    localparam int random_len   = 2000;
    localparam int cycle_limit  = 2 * (reset_len + directed_len + random_len);

    localparam addr_t pc_a  = 30'h0001_2340;
    localparam addr_t pc_b  = 30'h0001_2241;   // Same index as pc_a but another tag.
    localparam addr_t pc_c  = 30'h0055_6678;
    localparam addr_t pc_d  = 30'h0000_7700;
    localparam addr_t pc_e  = 30'h0000_0010;
    localparam addr_t tgt_a = 30'h0000_0400;
    localparam addr_t tgt_c = 30'h0abc_0001;
    localparam addr_t tgt_d = 30'h1234_5670;
    localparam bh_t   hist_d = 16'h001b;       // 0x0001 after shifting in 1, 0, 1, 1.

    logic       clk;
    logic       rst_n;
    logic       stall;
    logic       query_valid;
    addr_t      query_pc;
    logic       update_en;
    bp_update_t update;
    logic       pred_valid;
    bp_pred_t   pred;

    integer     seed;
    int         errors;
    int         cycle_count;
    bp_update_t no_upd;
    addr_t      pc_pool [8];

    // ==============================
    // Reference model state
    // ==============================
    logic [1:0] m_ctr    [depth];
    logic       m_valid  [depth];
    tag_t       m_tag    [depth];
    addr_t      m_target [depth];
    bh_t        m_ghr;
    bh_t        m_hist_q;
    addr_t      m_pc_q;
    logic       m_rd_valid;
    tag_t       m_rd_tag;
    addr_t      m_rd_target;
    logic [1:0] m_ctr_q;
    logic       m_pred_valid;

    branch_predictor #(
        .h_width (h_w)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .query_valid (query_valid),
        .query_pc    (query_pc),
        .update_en   (update_en),
        .update      (update),
        .pred_valid  (pred_valid),
        .pred        (pred)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Each pc and history bit lands on index bit (position mod h_w).
    function automatic logic [h_w-1:0] table_index(input addr_t pc, input bh_t bh);
        logic [h_w-1:0] idx;
        idx = '0;
        for (int i = 0; i < addr_w; i++) begin
            idx[i % h_w] = idx[i % h_w] ^ pc[i];
        end
        for (int i = 0; i < bh_w; i++) begin
            idx[i % h_w] = idx[i % h_w] ^ bh[i];
        end
        return idx;
    endfunction

    function automatic tag_t fold_tag(input addr_t pc);
        tag_t t;
        t = '0;
        for (int i = 0; i < addr_w; i++) begin
            t[i % k_w] = t[i % k_w] ^ pc[i];
        end
        return t;
    endfunction

    function automatic addr_t next_seq(input addr_t pc);
        if (pc[0]) begin
            return pc + 30'd1;
        end else begin
            return pc + 30'd2;
        end
    endfunction

    function automatic bp_update_t make_update(input addr_t pc, input bh_t bh,
                                               input addr_t target, input logic taken);
        bp_update_t u;
        u.pc     = pc;
        u.bh     = bh;
        u.target = target;
        u.taken  = taken;
        return u;
    endfunction

    // Query reads come first, so a same-edge update is not seen.
    task automatic model_clock();
        logic [h_w-1:0] qi;
        logic [h_w-1:0] ui;
        qi = table_index(query_pc, m_ghr);
        ui = table_index(update.pc, update.bh);
        if (!stall) begin
            m_pc_q      = query_pc;
            m_rd_valid  = m_valid[qi];
            m_rd_tag    = m_tag[qi];
            m_rd_target = m_target[qi];
        end
        if (!rst_n) begin
            m_pred_valid = 1'b0;
            m_ctr_q      = 2'b01;
            m_ghr        = '0;
            m_hist_q     = '0;
            for (int i = 0; i < depth; i++) begin
                m_ctr[i] = 2'b01;
            end
        end else begin
            if (!stall) begin
                m_pred_valid = query_valid;
                m_ctr_q      = m_ctr[qi];
                if (query_valid) begin
                    m_hist_q = m_ghr;
                end
            end
            if (update_en) begin
                if (update.taken && m_ctr[ui] != 2'b11) begin
                    m_ctr[ui] = m_ctr[ui] + 2'd1;
                end else if (!update.taken && m_ctr[ui] != 2'b00) begin
                    m_ctr[ui] = m_ctr[ui] - 2'd1;
                end
                m_ghr = {m_ghr[bh_w-2:0], update.taken};
            end
        end
        if (update_en && update.taken) begin
            m_valid[ui]  = 1'b1;   // The RAM has no reset.
            m_tag[ui]    = fold_tag(update.pc);
            m_target[ui] = update.target;
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is %h, expected %h (cycle %0d)", name, got, exp, cycle_count);
        end
    endtask

    task automatic compare_outputs();
        logic  exp_hit;
        logic  exp_taken;
        addr_t exp_npc;
        check_value("pred_valid", 64'(pred_valid), 64'(m_pred_valid));
        if (m_pred_valid) begin
            exp_hit   = m_rd_valid && (m_rd_tag == fold_tag(m_pc_q));
            exp_taken = exp_hit && m_ctr_q[1];
            exp_npc   = exp_taken ? m_rd_target : next_seq(m_pc_q);
            check_value("pred.hit", 64'(pred.hit), 64'(exp_hit));
            check_value("pred.taken", 64'(pred.taken), 64'(exp_taken));
            check_value("pred.npc", 64'(pred.npc), 64'(exp_npc));
            check_value("pred.bh", 64'(pred.bh), 64'(m_hist_q));
        end
    endtask

    task automatic clock_edge();
        @(posedge clk);
        model_clock();
        #2;
        compare_outputs();
    endtask

    task automatic apply(input logic qv, input addr_t pc, input logic st,
                         input logic ue, input bp_update_t upd);
        query_valid = qv;
        query_pc    = pc;
        stall       = st;
        update_en   = ue;
        update      = upd;
        clock_edge();
    endtask

    task automatic query(input addr_t pc);
        apply(1'b1, pc, 1'b0, 1'b0, no_upd);
    endtask

    task automatic resolve(input addr_t pc, input bh_t bh, input addr_t target,
                           input logic taken);
        apply(1'b0, '0, 1'b0, 1'b1, make_update(pc, bh, target, taken));
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        bp_pred_t    held;
        bp_update_t  upd;
        logic [31:0] rnd;
        logic [31:0] rnd2;
        clk         = 1'b0;
        seed        = 32'hfa98;
        errors      = 0;
        cycle_count = 0;
        no_upd      = '0;
        for (int i = 0; i < depth; i++) begin
            m_ctr[i]    = 2'b01;
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
        end
        m_ghr        = '0;
        m_hist_q     = '0;
        m_pred_valid = 1'b0;
        m_ctr_q      = 2'b01;
        pc_pool = '{pc_a, pc_b, pc_c, pc_d, pc_e, 30'h0000_0101, 30'h0012_3457, 30'h3fff_ffff};

        rst_n       = 1'b0;
        stall       = 1'b0;
        query_valid = 1'b0;
        query_pc    = '0;
        update_en   = 1'b0;
        update      = '0;
        repeat (reset_len) clock_edge();
        rst_n = 1'b1;

        // Cold start where every query misses.
        repeat (3) apply(1'b0, '0, 1'b0, 1'b0, no_upd);
        for (int i = 0; i < 8; i++) begin
            query(pc_pool[i]);
            check_value("pred.hit", 64'(pred.hit), 64'(0));
            check_value("pred.npc", 64'(pred.npc), 64'(next_seq(pc_pool[i])));
        end

        // Training and then a not-taken stream under a zero history.
        repeat (3) resolve(pc_a, '0, tgt_a, 1'b1);
        repeat (bh_w) resolve(pc_a ^ 30'd1, '0, '0, 1'b0);   // Flushes ghr to zero.
        query(pc_a);
        check_value("pred.taken", 64'(pred.taken), 64'(1));
        check_value("pred.npc", 64'(pred.npc), 64'(tgt_a));
        resolve(pc_a, '0, '0, 1'b0);
        query(pc_a);
        check_value("pred.taken", 64'(pred.taken), 64'(1));
        resolve(pc_a, '0, '0, 1'b0);
        query(pc_a);
        check_value("pred.hit", 64'(pred.hit), 64'(1));
        check_value("pred.taken", 64'(pred.taken), 64'(0));
        check_value("pred.npc", 64'(pred.npc), 64'(next_seq(pc_a)));

        // Tag mismatch on a shared index.
        query(pc_b);
        check_value("pred.hit", 64'(pred.hit), 64'(0));
        check_value("pred.npc", 64'(pred.npc), 64'(next_seq(pc_b)));
        query(pc_a);
        check_value("pred.hit", 64'(pred.hit), 64'(1));

        // Stall holds the prediction while the update still lands.
        query(pc_a);
        held = pred;
        apply(1'b1, pc_c, 1'b1, 1'b1, make_update(pc_c, 16'h0001, tgt_c, 1'b1));
        check_value("pred", 64'(pred), 64'(held));
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            apply(rnd[0], pc_pool[rnd[3:1]], 1'b1, 1'b0, no_upd);
            check_value("pred_valid", 64'(pred_valid), 64'(1));
            check_value("pred", 64'(pred), 64'(held));
        end
        query(pc_c);
        check_value("pred.taken", 64'(pred.taken), 64'(1));
        check_value("pred.npc", 64'(pred.npc), 64'(tgt_c));

        // History follows resolved outcomes.
        resolve(pc_e, '0, tgt_a, 1'b1);
        resolve(pc_e, '0, '0, 1'b0);
        resolve(pc_e, '0, tgt_a, 1'b1);
        resolve(pc_d, hist_d, tgt_d, 1'b1);
        query(pc_d);
        check_value("pred.bh", 64'(pred.bh), 64'(hist_d));
        check_value("pred.taken", 64'(pred.taken), 64'(1));
        check_value("pred.npc", 64'(pred.npc), 64'(tgt_d));

        // ==============================
        // Random traffic
        // ==============================
        for (int n = 0; n < random_len; n++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            upd.pc     = pc_pool[rnd[13:11]];
            upd.bh     = rnd[14] ? m_ghr : bh_t'(rnd[18:15]);   // Often matches live history.
            upd.target = rnd2[29:0];
            upd.taken  = rnd[19];
            apply(rnd[1:0] != 2'b00, pc_pool[rnd[4:2]], rnd[7:5] == 3'b000, rnd[8], upd);
        end
        apply(1'b0, '0, 1'b0, 1'b0, no_upd);

        $display("Run complete with %0d errors.", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
